// ==== common/readout_defines.svh ====
// readout core sizing, LED divider ratios and firmware version constants
`ifndef READOUT_DEFINES_SVH
`define READOUT_DEFINES_SVH

// front-end receivers feeding the arbiter
`define READOUT_N_FE 4

// front ends plus the trigger word source
`define READOUT_N_SRC 5

// readout word payload width
`define READOUT_DATA_W 32

// trigger number buffer, power of two
`define READOUT_TRIG_FIFO_DEPTH 8

// CLK_40 cycles per half period of the slow and fast blink
// scaled down so the blink is visible in simulation
`define READOUT_LED_SLOW_DIV 40
`define READOUT_LED_FAST_DIV 13

// version shown on the LEDs after reset
`define READOUT_VERSION 5

// slow blink full periods of the version window
`define READOUT_VERSION_TICKS 4

`endif

// ==== common/readout_pkg.sv ====
// readout side types: source words, receiver status, output word, source index
package readout_pkg;

`include "readout_defines.svh"

    // fall-through source word, data valid while not_empty
    typedef struct packed {
        logic                       not_empty;
        logic [`READOUT_DATA_W-1:0] data;
    } fe_word_t;

    // receiver status levels for the LEDs
    typedef struct packed {
        logic ready;
        logic decode_err;
        logic overflow;
    } fe_status_t;

    // word towards the external sink
    typedef struct packed {
        logic                       write;
        logic [`READOUT_DATA_W-1:0] data;
    } out_word_t;

    // arbiter source slots
    // trigger words sit in slot 0, receivers above
    typedef enum logic [2:0] {
        SRC_TRIG = 3'd0,
        SRC_FE0  = 3'd1,
        SRC_FE1  = 3'd2,
        SRC_FE2  = 3'd3,
        SRC_FE3  = 3'd4
    } src_idx_e;

endpackage

// ==== common/trig_pkg.sv ====
// trigger side types: sources, configuration, controller states, trigger number
package trig_pkg;

`include "readout_defines.svh"

    // trigger inputs, bit order also used for the mask
    typedef struct packed {
        logic monhit;
        logic lemo;
        logic tdc;
    } trig_src_t;

    // static configuration from the control side
    typedef struct packed {
        logic      enable;
        // 1 lets the matching source through
        trig_src_t src_mask;
    } trig_cfg_t;

    // controller FSM
    typedef enum logic [0:0] {
        TRIG_IDLE     = 1'b0,
        TRIG_WAIT_ACK = 1'b1
    } trig_state_e;

    // top bit of the readout word is the trigger header
    typedef logic [`READOUT_DATA_W-2:0] trig_num_t;

endpackage

// ==== dv/tb_readout_top.sv ====
// testbench for the trigger and readout core with receiver models and assertion checks
`timescale 1ns/1ps
`include "readout_defines.svh"

module tb_readout_top;
    import trig_pkg::*;
    import readout_pkg::*;

    localparam int N_FE = `READOUT_N_FE;
    localparam int N_SRC = `READOUT_N_SRC;
    localparam int WORDS = 20;
    localparam int N_ACCEPT = 4;
    localparam int VER_CYCLES = 2 * `READOUT_LED_SLOW_DIV * `READOUT_VERSION_TICKS;
    // bit order monhit, lemo, tdc
    localparam trig_src_t T_MONHIT = 3'b100;
    localparam trig_src_t T_LEMO = 3'b010;
    localparam trig_src_t T_TDC = 3'b001;

    logic                   CLK_40;
    logic                   i_rst;
    trig_src_t              i_trig;
    trig_cfg_t              i_cfg;
    logic                   i_veto_in;
    logic                   i_cmd_ready;
    fe_word_t [N_FE-1:0]    i_fe;
    fe_status_t [N_FE-1:0]  i_fe_status;
    logic [N_SRC-1:0]       i_sel;
    logic                   i_out_full;
    logic                   o_cmd_start;
    logic                   o_busy;
    logic [N_FE-1:0]        o_fe_read;
    out_word_t              o_out;
    logic [N_FE:0]          o_led;

    integer seed = 32'h9a2a_4702;
    int err_cnt = 0;
    int timeout_cnt = 0;
    int cyc;
    int ack_delay = 0;
    int trig_seen = 0;
    int accepted_cnt;
    int gen_cnt [N_FE];
    logic gen_en = 1'b0;
    logic [31:0] fe_q [N_FE][$];
    logic [31:0] fe_exp [N_FE][$];
    logic [N_SRC-1:0] wait_q;
    logic [2:0] last_src;
    logic have_last;
    // reference model of the trigger controller
    logic trig_masked;
    logic trig_prev;
    logic ready_prev;
    logic exp_start;
    logic exp_busy;
    logic accept;

    readout_top dut_i
    (
        .CLK_40      (CLK_40),
        .i_rst       (i_rst),
        .i_trig      (i_trig),
        .i_cfg       (i_cfg),
        .i_veto_in   (i_veto_in),
        .i_cmd_ready (i_cmd_ready),
        .i_fe        (i_fe),
        .i_fe_status (i_fe_status),
        .i_sel       (i_sel),
        .i_out_full  (i_out_full),
        .o_cmd_start (o_cmd_start),
        .o_busy      (o_busy),
        .o_fe_read   (o_fe_read),
        .o_out       (o_out),
        .o_led       (o_led)
    );

    initial
    begin
        CLK_40 = 1'b0;
        forever #2 CLK_40 = ~CLK_40;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        err_cnt++;
        $display("[FAIL] %s: expected %h actual %h", name, exp, act);
    endtask

    // edge on the given source, then quiet for two cycles
    task automatic pulse_trigger(input trig_src_t src);
        @(posedge CLK_40);
        i_trig <= src;
        @(posedge CLK_40);
        i_trig <= '0;
        repeat (2) @(posedge CLK_40);
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (o_busy && t < 100)
        begin
            @(posedge CLK_40);
            t++;
        end
        if (o_busy)
        begin
            timeout_cnt++;
            $display("timeout waiting for busy to clear");
        end
    endtask

    function automatic bit readout_drained();
        bit done;
        done = (trig_seen == accepted_cnt);
        for (int i = 0; i < N_FE; i++)
            if (i_sel[i + 1] && (gen_cnt[i] != WORDS || fe_exp[i].size() != 0))
                done = 1'b0;
        return done;
    endfunction

    // accepted: masked-in rising edge, idle, enabled, no veto
    assign trig_masked = |(i_trig & i_cfg.src_mask);
    assign accept = ~exp_busy & i_cfg.enable & trig_masked & ~trig_prev &
                    ~i_veto_in & ~i_out_full;

    always @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            trig_prev <= 1'b0;
            ready_prev <= 1'b0;
            exp_start <= 1'b0;
            exp_busy <= 1'b0;
            accepted_cnt <= 0;
            cyc <= 0;
        end
        else
        begin
            trig_prev <= trig_masked;
            ready_prev <= i_cmd_ready;
            exp_start <= accept;
            cyc <= cyc + 1;
            if (accept)
            begin
                exp_busy <= 1'b1;
                accepted_cnt <= accepted_cnt + 1;
            end
            else if (i_cmd_ready && !ready_prev)
                exp_busy <= 1'b0;
        end
    end

    // command sequencer: ready drops on start, rises after a random delay
    always @(posedge CLK_40)
    begin
        if (o_cmd_start)
        begin
            i_cmd_ready <= 1'b0;
            ack_delay = 6 + ($random(seed) & 7);
        end
        else if (!i_cmd_ready)
        begin
            if (ack_delay == 0)
                i_cmd_ready <= 1'b1;
            else
                ack_delay--;
        end
    end

    // fall-through receivers, data holds source index and sequence number
    always @(posedge CLK_40)
    begin
        logic [31:0] w;
        if (!i_rst)
        begin
            for (int i = 0; i < N_FE; i++)
            begin
                if (o_fe_read[i])
                begin
                    assert (fe_q[i].size() != 0)
                    else
                    begin
                        err_cnt++;
                        $display("receiver %0d was read while empty", i);
                    end
                    if (fe_q[i].size() != 0)
                        void'(fe_q[i].pop_front());
                end
                if (gen_en && gen_cnt[i] < WORDS && ($random(seed) & 3) == 0)
                begin
                    w = {1'b0, 3'(i + 1), 28'(gen_cnt[i])};
                    fe_q[i].push_back(w);
                    fe_exp[i].push_back(w);
                    gen_cnt[i]++;
                end
                i_fe[i] <= {fe_q[i].size() != 0, (fe_q[i].size() != 0) ? fe_q[i][0] : 32'h0};
            end
        end
    end

    // output scoreboard and round-robin check
    always @(posedge CLK_40)
    begin
        logic [31:0] exp_word;
        logic [2:0] wsrc;
        logic [N_SRC-1:0] others;
        logic [N_SRC-1:0] waiting;
        if (i_rst)
        begin
            have_last = 1'b0;
            trig_seen = 0;
            wait_q <= '0;
        end
        else
        begin
            if (o_out.write)
            begin
                wsrc = o_out.data[31] ? 3'(SRC_TRIG) : o_out.data[30:28];
                if (o_out.data[31])
                begin
                    assert (o_out.data[30:0] == 31'(trig_seen))
                    else report_mismatch("trigger number", trig_seen, o_out.data[30:0]);
                    trig_seen++;
                end
                else if (wsrc >= 1 && wsrc <= N_FE && fe_exp[wsrc - 1].size() != 0)
                begin
                    exp_word = fe_exp[wsrc - 1].pop_front();
                    assert (o_out.data == exp_word)
                    else report_mismatch("receiver word", exp_word, o_out.data);
                end
                else
                begin
                    err_cnt++;
                    $display("output word %h matches no pending receiver word", o_out.data);
                end
                // wait_q holds the waiting receivers of the grant cycle
                others = wait_q & ~(N_SRC'(1) << wsrc);
                assert (!(have_last && wsrc == last_src && others != '0))
                else
                begin
                    err_cnt++;
                    $display("source %0d granted twice while %b waited", wsrc, others);
                end
                last_src = wsrc;
                have_last = 1'b1;
            end
            waiting = '0;
            for (int i = 0; i < N_FE; i++)
                waiting[i + 1] = i_fe[i].not_empty & i_sel[i + 1];
            wait_q <= waiting;
        end
    end

    assert property (@(posedge CLK_40) $fell(i_rst) |-> !o_cmd_start && !o_busy && !o_out.write)
    else report_mismatch("reset state", 0, $sampled({o_cmd_start, o_busy, o_out.write}));

    assert property (@(posedge CLK_40) disable iff (i_rst) o_cmd_start == exp_start)
    else report_mismatch("cmd start", $sampled(exp_start), $sampled(o_cmd_start));

    assert property (@(posedge CLK_40) disable iff (i_rst) o_busy == exp_busy)
    else report_mismatch("busy", $sampled(exp_busy), $sampled(o_busy));

    assert property (@(posedge CLK_40) disable iff (i_rst) $past(i_out_full) |-> !o_out.write)
    else
    begin
        err_cnt++;
        $display("sink written while it was full");
    end

    assert property (@(posedge CLK_40) disable iff (i_rst) (o_fe_read & ~i_sel[N_SRC-1:1]) == '0)
    else
    begin
        err_cnt++;
        $display("unselected receiver read, strobes %b", $sampled(o_fe_read));
    end

    assert property (@(posedge CLK_40) disable iff (i_rst)
                     cyc < VER_CYCLES |-> o_led == `READOUT_VERSION)
    else report_mismatch("version leds", `READOUT_VERSION, $sampled(o_led));

    // receiver 0 not ready but overflowing, receiver 1 ready and overflowing
    assert property (@(posedge CLK_40) disable iff (i_rst)
                     cyc >= VER_CYCLES |-> !o_led[0] && o_led[1])
    else report_mismatch("status leds", 2'b10, $sampled(o_led[1:0]));

    initial
    begin
        int t;
        i_rst = 1'b1;
        i_trig = '0;
        i_cfg = '{enable: 1'b1, src_mask: 3'b110};
        i_veto_in = 1'b0;
        i_cmd_ready = 1'b1;
        i_fe = '0;
        i_fe_status[0] = '{ready: 1'b0, decode_err: 1'b0, overflow: 1'b1};
        i_fe_status[1] = '{ready: 1'b1, decode_err: 1'b0, overflow: 1'b1};
        i_fe_status[2] = '{ready: 1'b1, decode_err: 1'b1, overflow: 1'b0};
        i_fe_status[3] = '{ready: 1'b1, decode_err: 1'b0, overflow: 1'b0};
        // receiver 2 left out of the readout
        i_sel = 5'b10111;
        i_out_full = 1'b0;
        for (int i = 0; i < N_FE; i++)
            gen_cnt[i] = 0;
        repeat (4) @(posedge CLK_40);
        i_rst <= 1'b0;
        gen_en <= 1'b1;

        // three accepted triggers, numbers 0 to 2
        repeat (3)
        begin
            pulse_trigger(T_LEMO);
            wait_idle();
        end
        // tdc is masked off
        pulse_trigger(T_TDC);
        i_veto_in <= 1'b1;
        pulse_trigger(T_MONHIT);
        i_veto_in <= 1'b0;
        // second edge arrives while busy
        pulse_trigger(T_LEMO);
        pulse_trigger(T_MONHIT);
        wait_idle();
        // back-pressure, receivers pile up and the trigger is vetoed
        @(posedge CLK_40);
        i_out_full <= 1'b1;
        pulse_trigger(T_MONHIT);
        repeat (30) @(posedge CLK_40);
        i_out_full <= 1'b0;

        t = 0;
        while (!readout_drained() && t < 2000)
        begin
            @(posedge CLK_40);
            t++;
        end
        if (!readout_drained())
        begin
            timeout_cnt++;
            $display("timeout waiting for the readout to drain");
        end
        // run past the version window for the LED checks
        t = 0;
        while (cyc < VER_CYCLES + 60 && t < 1000)
        begin
            @(posedge CLK_40);
            t++;
        end
        if (cyc < VER_CYCLES + 60)
        begin
            timeout_cnt++;
            $display("timeout waiting for the end of the version window");
        end
        assert (trig_seen == N_ACCEPT)
        else report_mismatch("trigger count", N_ACCEPT, trig_seen);
        assert (fe_exp[2].size() == WORDS)
        else report_mismatch("unselected receiver words", WORDS, fe_exp[2].size());

        $display("errors: %0d, timeouts: %0d, trigger words: %0d", err_cnt, timeout_cnt,
                 trig_seen);
        if (err_cnt == 0 && timeout_cnt == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== hw/readout_arbiter.sv ====
// round-robin read arbiter merging trigger and receiver words into one stream
`timescale 1ns/1ps
`include "readout_defines.svh"

module readout_arbiter
(
    input  logic                                      CLK_40,
    input  logic                                      i_rst,
    input  readout_pkg::fe_word_t [`READOUT_N_SRC-1:0] i_src,
    input  logic [`READOUT_N_SRC-1:0]                 i_sel,
    input  logic                                      i_out_full,
    output logic [`READOUT_N_SRC-1:0]                 o_read,
    output readout_pkg::out_word_t                    o_out
);
    import readout_pkg::*;

    localparam int N_SRC = `READOUT_N_SRC;
    localparam int IDX_W = $bits(src_idx_e);

    // next source in line for priority
    src_idx_e                   ptr_q;
    src_idx_e                   grant_idx;
    logic                       grant_vld;
    logic [N_SRC-1:0]           req;
    logic                       write_q;
    logic [`READOUT_DATA_W-1:0] data_q;

    // sink full blocks all requests
    always_comb
    begin
        for (int i = 0; i < N_SRC; i++)
            req[i] = i_src[i].not_empty & i_sel[i] & ~i_out_full;
    end

    // cyclic search starting at the pointer
    always_comb
    begin
        int idx;
        grant_vld = 1'b0;
        grant_idx = ptr_q;
        for (int k = 0; k < N_SRC; k++)
        begin
            idx = int'(ptr_q) + k;
            if (idx >= N_SRC)
                idx = idx - N_SRC;
            if (!grant_vld && req[idx])
            begin
                grant_vld = 1'b1;
                grant_idx = src_idx_e'(idx[IDX_W-1:0]);
            end
        end
    end

    // one-hot pop strobe to the granted source
    always_comb
    begin
        o_read = '0;
        if (grant_vld)
            o_read[grant_idx] = 1'b1;
    end

    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            ptr_q <= SRC_TRIG;
            write_q <= 1'b0;
        end
        else
        begin
            write_q <= grant_vld;
            // move past the winner, wrap back to the trigger slot
            if (grant_vld)
                ptr_q <= (grant_idx == src_idx_e'(N_SRC - 1)) ?
                         SRC_TRIG : src_idx_e'(grant_idx + 1'b1);
        end
    end

    // granted word goes out one cycle after its pop
    always_ff @(posedge CLK_40)
    begin
        if (grant_vld)
            data_q <= i_src[grant_idx].data;
    end

    assign o_out.write = write_q;
    assign o_out.data = data_q;

endmodule

// ==== hw/readout_top.sv ====
// trigger and readout core: trigger controller, trigger buffer, arbiter and LEDs
`timescale 1ns/1ps
`include "readout_defines.svh"

module readout_top
(
    input  logic                                        CLK_40,
    input  logic                                        i_rst,
    input  trig_pkg::trig_src_t                         i_trig,
    input  trig_pkg::trig_cfg_t                         i_cfg,
    input  logic                                        i_veto_in,
    input  logic                                        i_cmd_ready,
    input  readout_pkg::fe_word_t [`READOUT_N_FE-1:0]   i_fe,
    input  readout_pkg::fe_status_t [`READOUT_N_FE-1:0] i_fe_status,
    input  logic [`READOUT_N_SRC-1:0]                   i_sel,
    input  logic                                        i_out_full,
    output logic                                        o_cmd_start,
    output logic                                        o_busy,
    output logic [`READOUT_N_FE-1:0]                    o_fe_read,
    output readout_pkg::out_word_t                      o_out,
    output logic [`READOUT_N_FE:0]                      o_led
);
    import trig_pkg::*;
    import readout_pkg::*;

    localparam int N_FE = `READOUT_N_FE;
    localparam int N_SRC = `READOUT_N_SRC;

    logic                    push;
    trig_num_t               push_num;
    logic                    fifo_full;
    logic                    trig_read;
    fe_word_t                trig_word;
    fe_word_t [N_SRC-1:0]    src_words;
    logic [N_SRC-1:0]        arb_read;

    // trigger words in slot SRC_TRIG, receivers from SRC_FE0 up
    assign src_words = {i_fe, trig_word};
    assign trig_read = arb_read[SRC_TRIG];
    assign o_fe_read = arb_read[SRC_FE0 +: N_FE];

    trigger_ctrl trigger_ctrl_i
    (
        .CLK_40      (CLK_40),
        .i_rst       (i_rst),
        .i_trig      (i_trig),
        .i_cfg       (i_cfg),
        .i_veto_in   (i_veto_in),
        .i_out_full  (i_out_full),
        .i_fifo_full (fifo_full),
        .i_cmd_ready (i_cmd_ready),
        .o_cmd_start (o_cmd_start),
        .o_busy      (o_busy),
        .o_push      (push),
        .o_num       (push_num)
    );

    trigger_fifo trigger_fifo_i
    (
        .CLK_40 (CLK_40),
        .i_rst  (i_rst),
        .i_push (push),
        .i_num  (push_num),
        .i_read (trig_read),
        .o_full (fifo_full),
        .o_word (trig_word)
    );

    readout_arbiter readout_arbiter_i
    (
        .CLK_40     (CLK_40),
        .i_rst      (i_rst),
        .i_src      (src_words),
        .i_sel      (i_sel),
        .i_out_full (i_out_full),
        .o_read     (arb_read),
        .o_out      (o_out)
    );

    status_led status_led_i
    (
        .CLK_40      (CLK_40),
        .i_rst       (i_rst),
        .i_fe_status (i_fe_status),
        .i_busy      (o_busy),
        .i_out_full  (i_out_full),
        .o_led       (o_led)
    );

endmodule

// ==== hw/status_led.sv ====
// status LEDs: version window after reset, then receiver and trigger blink status
`timescale 1ns/1ps
`include "readout_defines.svh"

module status_led
(
    input  logic                                        CLK_40,
    input  logic                                        i_rst,
    input  readout_pkg::fe_status_t [`READOUT_N_FE-1:0] i_fe_status,
    input  logic                                        i_busy,
    input  logic                                        i_out_full,
    output logic [`READOUT_N_FE:0]                      o_led
);
    localparam int N_FE = `READOUT_N_FE;
    localparam int LED_W = N_FE + 1;
    localparam int SLOW_W = $clog2(`READOUT_LED_SLOW_DIV);
    localparam int FAST_W = $clog2(`READOUT_LED_FAST_DIV);
    localparam int VER_W = $clog2(`READOUT_VERSION_TICKS + 1);
    localparam logic [SLOW_W-1:0] SLOW_LAST = SLOW_W'(`READOUT_LED_SLOW_DIV - 1);
    localparam logic [FAST_W-1:0] FAST_LAST = FAST_W'(`READOUT_LED_FAST_DIV - 1);
    localparam logic [VER_W-1:0] VER_LAST = VER_W'(`READOUT_VERSION_TICKS);
    localparam logic [LED_W-1:0] VERSION_LEDS = LED_W'(`READOUT_VERSION);

    logic [SLOW_W-1:0] slow_cnt_q;
    logic [FAST_W-1:0] fast_cnt_q;
    logic [VER_W-1:0]  ver_cnt_q;
    logic              slow_q;
    logic              fast_q;
    logic              slow_wrap;
    logic              fast_wrap;
    logic              show_version;
    logic [LED_W-1:0]  run_led;

    assign slow_wrap = (slow_cnt_q == SLOW_LAST);
    assign fast_wrap = (fast_cnt_q == FAST_LAST);

    // blink dividers, level toggles every half period
    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            slow_cnt_q <= '0;
            fast_cnt_q <= '0;
            slow_q <= 1'b0;
            fast_q <= 1'b0;
        end
        else
        begin
            slow_cnt_q <= slow_wrap ? '0 : slow_cnt_q + 1'b1;
            fast_cnt_q <= fast_wrap ? '0 : fast_cnt_q + 1'b1;
            if (slow_wrap)
                slow_q <= ~slow_q;
            if (fast_wrap)
                fast_q <= ~fast_q;
        end
    end

    // one tick per slow full period, at the falling toggle
    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
            ver_cnt_q <= '0;
        else if (show_version && slow_wrap && slow_q)
            ver_cnt_q <= ver_cnt_q + 1'b1;
    end

    assign show_version = (ver_cnt_q != VER_LAST);

    always_comb
    begin
        // receivers: dark when not ready, fast blink on decode errors
        for (int i = 0; i < N_FE; i++)
            run_led[i] = i_fe_status[i].ready &
                         ((i_fe_status[i].decode_err ? fast_q : slow_q) |
                          i_fe_status[i].overflow);
        // top LED: trigger busy and sink full
        run_led[N_FE] = (i_busy ? fast_q : slow_q) | i_out_full;
    end

    assign o_led = show_version ? VERSION_LEDS : run_led;

endmodule

// ==== hw/trigger/trigger_ctrl.sv ====
// trigger controller: masks and vetoes sources, starts commands, numbers accepted triggers
`timescale 1ns/1ps

module trigger_ctrl
(
    input  logic                CLK_40,
    input  logic                i_rst,
    input  trig_pkg::trig_src_t i_trig,
    input  trig_pkg::trig_cfg_t i_cfg,
    input  logic                i_veto_in,
    input  logic                i_out_full,
    input  logic                i_fifo_full,
    input  logic                i_cmd_ready,
    output logic                o_cmd_start,
    output logic                o_busy,
    output logic                o_push,
    output trig_pkg::trig_num_t o_num
);
    import trig_pkg::*;

    trig_state_e state_q;
    trig_num_t   num_q;
    logic        trig_masked;
    logic        trig_prev_q;
    logic        trig_edge;
    logic        ready_prev_q;
    logic        ack;
    logic        veto;
    logic        accept;

    // any masked-in source fires the trigger
    assign trig_masked = |(i_trig & i_cfg.src_mask);
    assign trig_edge = trig_masked & ~trig_prev_q;

    // sequencer ready going high acknowledges the command
    assign ack = i_cmd_ready & ~ready_prev_q;

    // full trigger buffer vetoes as well, pushes never overflow
    assign veto = i_veto_in | i_out_full | i_fifo_full;

    // edges outside idle are simply dropped
    assign accept = (state_q == TRIG_IDLE) & i_cfg.enable & trig_edge & ~veto;

    // previous levels for edge detection
    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            trig_prev_q <= 1'b0;
            ready_prev_q <= 1'b0;
        end
        else
        begin
            trig_prev_q <= trig_masked;
            ready_prev_q <= i_cmd_ready;
        end
    end

    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            state_q <= TRIG_IDLE;
            o_cmd_start <= 1'b0;
            o_push <= 1'b0;
        end
        else
        begin
            // single cycle strobes
            o_cmd_start <= 1'b0;
            o_push <= 1'b0;
            case (state_q)
                TRIG_IDLE:
                begin
                    if (accept)
                    begin
                        o_cmd_start <= 1'b1;
                        o_push <= 1'b1;
                        state_q <= TRIG_WAIT_ACK;
                    end
                end
                TRIG_WAIT_ACK:
                begin
                    if (ack)
                        state_q <= TRIG_IDLE;
                end
                default:
                begin
                    state_q <= TRIG_IDLE;
                end
            endcase
        end
    end

    // number advances after it was pushed
    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
            num_q <= '0;
        else if (o_push)
            num_q <= num_q + 1'b1;
    end

    assign o_busy = (state_q == TRIG_WAIT_ACK);
    assign o_num = num_q;

endmodule

// ==== hw/trigger/trigger_fifo.sv ====
// trigger number buffer, head presented as a fall-through readout word
`timescale 1ns/1ps
`include "readout_defines.svh"

module trigger_fifo
(
    input  logic                  CLK_40,
    input  logic                  i_rst,
    input  logic                  i_push,
    input  trig_pkg::trig_num_t   i_num,
    input  logic                  i_read,
    output logic                  o_full,
    output readout_pkg::fe_word_t o_word
);
    import trig_pkg::*;

    localparam int DEPTH = `READOUT_TRIG_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0] CNT_FULL = (PTR_W + 1)'(DEPTH);

    trig_num_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             empty;
    logic             do_push;
    logic             do_pop;

    assign empty = (count_q == '0);
    assign o_full = (count_q == CNT_FULL);
    assign do_push = i_push & ~o_full;
    assign do_pop = i_read & ~empty;

    // storage
    always_ff @(posedge CLK_40)
    begin
        if (do_push)
            mem[wr_ptr_q] <= i_num;
    end

    // pointers and occupancy
    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            if (do_pop)
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            // simultaneous push and pop keep the count
            case ({do_push, do_pop})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // header bit marks trigger words in the stream
    assign o_word.not_empty = ~empty;
    assign o_word.data = {1'b1, mem[rd_ptr_q]};

endmodule

// ==== project.f ====
+incdir+common
common/trig_pkg.sv
common/readout_pkg.sv
hw/trigger/trigger_ctrl.sv
hw/trigger/trigger_fifo.sv
hw/readout_arbiter.sv
hw/status_led.sv
hw/readout_top.sv
dv/tb_readout_top.sv
